//--- eeprom_defs.svh
`ifndef EEPROM_DEFS_SVH
`define EEPROM_DEFS_SVH

// Fixed upper nibble of every control byte
`define EE_DEV_CODE 4'b1010

`define EE_DATA_W 8

// 3 block bits on top of the address byte
`define EE_ADDR_W 11

`define EE_DEPTH 2048

// One serial slave per bus
`define EE_PORTS 2

`endif

//--- eeprom_pkg.sv
`include "eeprom_defs.svh"

package eeprom_pkg;

    typedef logic [`EE_DATA_W-1:0] data_t;

    // {block[2:0], address byte}
    typedef logic [`EE_ADDR_W-1:0] addr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CONTROL,
        ST_ADDRESS,
        ST_DATA,
        // Control byte after a repeated start
        ST_READ_CONTROL,
        ST_SEND,
        ST_ACK
    } slave_state_e;

endpackage

//--- line_sampler.sv
`timescale 1ns/1ps

module line_sampler (
    input  logic scl,
    input  logic rst_n,
    input  logic sck,
    input  logic sda,
    output logic sda_s,
    output logic start,
    output logic stop,
    output logic sck_rise,
    output logic sck_fall
);

    logic [1:0] sck_sync;
    logic [1:0] sda_sync;
    logic       sck_s;
    logic       sck_d;
    logic       sda_d;

    // Idle bus reads high on both lines
    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            sck_sync <= 2'b11;
            sda_sync <= 2'b11;
            sck_d    <= 1'b1;
            sda_d    <= 1'b1;
        end
        else
        begin
            sck_sync <= {sck_sync[0], sck};
            sda_sync <= {sda_sync[0], sda};
            sck_d    <= sck_sync[1];
            sda_d    <= sda_sync[1];
        end
    end

    assign sck_s = sck_sync[1];
    assign sda_s = sda_sync[1];

    assign sck_rise = sck_s & ~sck_d;
    assign sck_fall = ~sck_s & sck_d;

    // sda edge with sck high over both samples
    assign start = sck_s & sck_d & sda_d & ~sda_s;
    assign stop  = sck_s & sck_d & ~sda_d & sda_s;

endmodule

//--- serial_slave.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module serial_slave (
    input  logic              scl,
    input  logic              rst_n,
    input  logic              sda_s,
    input  logic              start,
    input  logic              stop,
    input  logic              sck_rise,
    input  logic              sck_fall,
    output logic              sda_oe,
    output logic              req,
    output logic              we,
    output eeprom_pkg::addr_t addr,
    output eeprom_pkg::data_t wdata,
    input  logic              gnt,
    input  logic              rvalid,
    input  eeprom_pkg::data_t rdata
);

    eeprom_pkg::slave_state_e state;
    eeprom_pkg::slave_state_e ack_next;
    logic [3:0]               bit_cnt;
    logic                     addr_valid;
    logic [2:0]               blk;
    eeprom_pkg::data_t        addr_byte;
    eeprom_pkg::data_t        shift;
    eeprom_pkg::data_t        rbuf;
    eeprom_pkg::data_t        in_byte;
    logic                     dev_ok;
    logic                     last_bit;

    // Byte as it stands once the current sample is shifted in
    assign in_byte  = {shift[`EE_DATA_W-2:0], sda_s};
    assign dev_ok   = (in_byte[7:4] == `EE_DEV_CODE);
    assign last_bit = sck_rise && (bit_cnt == 4'd7);

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            state      <= eeprom_pkg::ST_IDLE;
            ack_next   <= eeprom_pkg::ST_IDLE;
            bit_cnt    <= 4'd0;
            addr_valid <= 1'b0;
            sda_oe     <= 1'b0;
            req        <= 1'b0;
        end
        else
        begin
            // Request held until the arbiter answers
            if (gnt)
                req <= 1'b0;

            if (stop)
            begin
                state      <= eeprom_pkg::ST_IDLE;
                bit_cnt    <= 4'd0;
                addr_valid <= 1'b0;
                sda_oe     <= 1'b0;
            end
            else if (start)
            begin
                // Repeated start after an address byte begins a read
                state   <= addr_valid ? eeprom_pkg::ST_READ_CONTROL : eeprom_pkg::ST_CONTROL;
                bit_cnt <= 4'd0;
                sda_oe  <= 1'b0;
            end
            else
            begin
                case (state)
                    eeprom_pkg::ST_CONTROL,
                    eeprom_pkg::ST_ADDRESS,
                    eeprom_pkg::ST_DATA,
                    eeprom_pkg::ST_READ_CONTROL:
                    begin
                        if (sck_rise && bit_cnt < 4'd8)
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            if (bit_cnt == 4'd7)
                            begin
                                case (state)
                                    eeprom_pkg::ST_CONTROL:
                                    begin
                                        addr_valid <= 1'b0;
                                        if (dev_ok && !in_byte[0])
                                            ack_next <= eeprom_pkg::ST_ADDRESS;
                                        else
                                            state <= eeprom_pkg::ST_IDLE;
                                    end
                                    eeprom_pkg::ST_ADDRESS:
                                    begin
                                        addr_valid <= 1'b1;
                                        ack_next   <= eeprom_pkg::ST_DATA;
                                    end
                                    eeprom_pkg::ST_DATA:
                                    begin
                                        addr_valid <= 1'b0;
                                        req        <= 1'b1;
                                        ack_next   <= eeprom_pkg::ST_IDLE;
                                    end
                                    default:
                                    begin
                                        addr_valid <= 1'b0;
                                        if (dev_ok && in_byte[0])
                                        begin
                                            req      <= 1'b1;
                                            ack_next <= eeprom_pkg::ST_SEND;
                                        end
                                        else
                                            state <= eeprom_pkg::ST_IDLE;
                                    end
                                endcase
                            end
                        end
                        else if (sck_fall && bit_cnt == 4'd8)
                        begin
                            // Pull low for the ninth clock
                            sda_oe  <= 1'b1;
                            state   <= eeprom_pkg::ST_ACK;
                            bit_cnt <= 4'd0;
                        end
                    end
                    eeprom_pkg::ST_ACK:
                    begin
                        if (sck_fall)
                        begin
                            state <= ack_next;
                            if (ack_next == eeprom_pkg::ST_SEND)
                            begin
                                sda_oe  <= ~rbuf[7];
                                bit_cnt <= 4'd1;
                            end
                            else
                                sda_oe <= 1'b0;
                        end
                    end
                    eeprom_pkg::ST_SEND:
                    begin
                        if (sck_fall)
                        begin
                            if (bit_cnt == 4'd8)
                            begin
                                // Master acknowledge is not checked
                                sda_oe  <= 1'b0;
                                state   <= eeprom_pkg::ST_IDLE;
                                bit_cnt <= 4'd0;
                            end
                            else
                            begin
                                sda_oe  <= ~rbuf[6];
                                bit_cnt <= bit_cnt + 4'd1;
                            end
                        end
                    end
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (sck_rise)
            shift <= in_byte;

        if (last_bit)
        begin
            case (state)
                eeprom_pkg::ST_CONTROL:
                    blk <= in_byte[3:1];
                eeprom_pkg::ST_ADDRESS:
                    addr_byte <= in_byte;
                eeprom_pkg::ST_DATA:
                begin
                    addr  <= {blk, addr_byte};
                    wdata <= in_byte;
                    we    <= 1'b1;
                end
                eeprom_pkg::ST_READ_CONTROL:
                begin
                    addr <= {in_byte[3:1], addr_byte};
                    we   <= 1'b0;
                end
                default:
                begin
                end
            endcase
        end

        // MSB leaves first
        if (rvalid)
            rbuf <= rdata;
        else if (state == eeprom_pkg::ST_SEND && sck_fall)
            rbuf <= {rbuf[6:0], 1'b0};
    end

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module mem_arbiter (
    input  logic                 scl,
    input  logic                 rst_n,
    input  logic [`EE_PORTS-1:0] req,
    input  logic [`EE_PORTS-1:0] we,
    input  eeprom_pkg::addr_t    addr [`EE_PORTS],
    input  eeprom_pkg::data_t    wdata [`EE_PORTS],
    output logic [`EE_PORTS-1:0] gnt,
    output logic [`EE_PORTS-1:0] rvalid,
    output logic                 mem_en,
    output logic                 mem_we,
    output eeprom_pkg::addr_t    mem_addr,
    output eeprom_pkg::data_t    mem_wdata,
    input  logic                 mem_rvalid
);

    localparam int IDX_W = (`EE_PORTS > 1) ? $clog2(`EE_PORTS) : 1;

    logic [IDX_W-1:0] last;
    logic [IDX_W-1:0] pick;
    logic             found;
    logic             busy;

    // Search starts just past the port served last
    always_comb
    begin
        int cand;
        found = 1'b0;
        pick  = last;
        for (int k = 1; k <= `EE_PORTS; k++)
        begin
            cand = (int'(last) + k) % `EE_PORTS;
            if (!found && req[cand])
            begin
                found = 1'b1;
                pick  = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (!rst_n)
        begin
            gnt    <= '0;
            mem_en <= 1'b0;
            busy   <= 1'b0;
            last   <= '0;
        end
        else
        begin
            gnt    <= '0;
            mem_en <= 1'b0;
            if (busy)
            begin
                // Writes free the store after the enable cycle, reads after rvalid
                if ((mem_en && mem_we) || mem_rvalid)
                    busy <= 1'b0;
            end
            else if (found)
            begin
                gnt[pick] <= 1'b1;
                mem_en    <= 1'b1;
                busy      <= 1'b1;
                last      <= pick;
            end
        end
    end

    always_ff @(posedge scl)
    begin
        if (!busy && found)
        begin
            mem_we    <= we[pick];
            mem_addr  <= addr[pick];
            mem_wdata <= wdata[pick];
        end
    end

    always_comb
    begin
        rvalid       = '0;
        rvalid[last] = mem_rvalid;
    end

endmodule

//--- byte_store.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module byte_store (
    input  logic              scl,
    input  logic              mem_en,
    input  logic              mem_we,
    input  eeprom_pkg::addr_t mem_addr,
    input  eeprom_pkg::data_t mem_wdata,
    output eeprom_pkg::data_t rdata,
    output logic              mem_rvalid
);

    eeprom_pkg::data_t mem [`EE_DEPTH];

    always_ff @(posedge scl)
    begin
        if (mem_en)
        begin
            if (mem_we)
                mem[mem_addr] <= mem_wdata;
            else
                rdata <= mem[mem_addr];
        end
    end

    // High in the cycle rdata is valid
    always_ff @(posedge scl)
    begin
        mem_rvalid <= mem_en && !mem_we;
    end

endmodule

//--- dual_port_eeprom.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module dual_port_eeprom (
    input  logic                 scl,
    input  logic                 rst_n,
    input  logic [`EE_PORTS-1:0] sck,
    input  logic [`EE_PORTS-1:0] sda,
    output logic [`EE_PORTS-1:0] sda_oe
);

    logic [`EE_PORTS-1:0] sda_s;
    logic [`EE_PORTS-1:0] start;
    logic [`EE_PORTS-1:0] stop;
    logic [`EE_PORTS-1:0] sck_rise;
    logic [`EE_PORTS-1:0] sck_fall;
    logic [`EE_PORTS-1:0] req;
    logic [`EE_PORTS-1:0] we;
    logic [`EE_PORTS-1:0] gnt;
    logic [`EE_PORTS-1:0] rvalid;
    eeprom_pkg::addr_t    addr [`EE_PORTS];
    eeprom_pkg::data_t    wdata [`EE_PORTS];

    logic                 mem_en;
    logic                 mem_we;
    logic                 mem_rvalid;
    eeprom_pkg::addr_t    mem_addr;
    eeprom_pkg::data_t    mem_wdata;
    eeprom_pkg::data_t    rdata;

    // One sampler and slave per bus
    generate
        for (genvar i = 0; i < `EE_PORTS; i++)
        begin : g_port
            line_sampler u_sampler (
                .scl      (scl),
                .rst_n    (rst_n),
                .sck      (sck[i]),
                .sda      (sda[i]),
                .sda_s    (sda_s[i]),
                .start    (start[i]),
                .stop     (stop[i]),
                .sck_rise (sck_rise[i]),
                .sck_fall (sck_fall[i])
            );

            serial_slave u_slave (
                .scl      (scl),
                .rst_n    (rst_n),
                .sda_s    (sda_s[i]),
                .start    (start[i]),
                .stop     (stop[i]),
                .sck_rise (sck_rise[i]),
                .sck_fall (sck_fall[i]),
                .sda_oe   (sda_oe[i]),
                .req      (req[i]),
                .we       (we[i]),
                .addr     (addr[i]),
                .wdata    (wdata[i]),
                .gnt      (gnt[i]),
                .rvalid   (rvalid[i]),
                .rdata    (rdata)
            );
        end
    endgenerate

    mem_arbiter u_arb (
        .scl        (scl),
        .rst_n      (rst_n),
        .req        (req),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .gnt        (gnt),
        .rvalid     (rvalid),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid)
    );

    // Read data fans out to both slaves, rvalid picks the owner
    byte_store u_store (
        .scl        (scl),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .rdata      (rdata),
        .mem_rvalid (mem_rvalid)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD     = 100,
    parameter int RST_CYCLES = 10,
    parameter int DRV_DLY    = 10
) (
    output logic scl,
    output logic rst_n
);

    initial
    begin
        scl = 1'b0;
        forever #(PERIOD / 2) scl = ~scl;
    end

    initial
    begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge scl);
        #DRV_DLY;
        rst_n = 1'b1;
    end

endmodule

//--- tb_dual_port_eeprom.sv
`timescale 1ns/1ps
`include "eeprom_defs.svh"

module tb_dual_port_eeprom;

    localparam int DRV_DLY = 10;
    localparam int HALF    = 10;
    localparam int N_WR_RD = 8;
    localparam int N_BAD   = 4;
    localparam int N_DUAL  = 4;
    localparam int N_ABORT = 4;

    // A read is four 9-bit bytes plus two starts and a stop
    localparam int READ_CYC    = 4 * 9 * 2 * HALF + 3 * 3 * HALF;
    localparam int N_TRANS     = 2 * N_WR_RD + 16 + 3 * N_BAD + 2 * N_DUAL + 3 * N_ABORT;
    localparam int CYCLE_LIMIT = N_TRANS * READ_CYC + 1000;

    logic                 scl;
    logic                 rst_n;
    logic [`EE_PORTS-1:0] sck;
    logic [`EE_PORTS-1:0] sda_drv;
    logic [`EE_PORTS-1:0] sda_line;
    logic [`EE_PORTS-1:0] sda_oe;

    eeprom_pkg::data_t model [`EE_DEPTH];
    eeprom_pkg::addr_t dual_addr [2];
    eeprom_pkg::data_t dual_data [2];
    eeprom_pkg::data_t dual_rd [2];
    int                cycle_cnt;

    // Open-drain line, DUT pulls low with sda_oe
    assign sda_line = sda_drv & ~sda_oe;

    tb_clock u_clk (
        .scl   (scl),
        .rst_n (rst_n)
    );

    dual_port_eeprom u_dut (
        .scl    (scl),
        .rst_n  (rst_n),
        .sck    (sck),
        .sda    (sda_line),
        .sda_oe (sda_oe)
    );

    task automatic check_byte(input string name, input eeprom_pkg::data_t exp,
                              input eeprom_pkg::data_t act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: expected 8'h%02h, actual 8'h%02h", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "byte compare failed");
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("MISMATCH %s: expected %0b, actual %0b", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "bit compare failed");
        end
    endtask

    function automatic eeprom_pkg::data_t rand_byte();
        logic [31:0] r;
        r = $urandom;
        return r[`EE_DATA_W-1:0];
    endfunction

    function automatic eeprom_pkg::addr_t rand_addr();
        logic [31:0] r;
        r = $urandom;
        return r[`EE_ADDR_W-1:0];
    endfunction

    function automatic logic rand_port();
        logic [31:0] r;
        r = $urandom;
        return r[0];
    endfunction

    task automatic step(input int n);
        repeat (n) @(posedge scl);
        #DRV_DLY;
    endtask

    // Also serves as repeated start with sck low
    task automatic send_start(input logic p);
        sda_drv[p] = 1'b1;
        step(HALF);
        sck[p] = 1'b1;
        step(HALF);
        sda_drv[p] = 1'b0;
        step(HALF);
        sck[p] = 1'b0;
    endtask

    task automatic send_stop(input logic p);
        sda_drv[p] = 1'b0;
        step(HALF);
        sck[p] = 1'b1;
        step(HALF);
        sda_drv[p] = 1'b1;
        step(HALF);
    endtask

    // Line sampled at the end of the high phase
    task automatic clock_bit(input logic p, input logic b, output logic seen);
        sda_drv[p] = b;
        step(HALF);
        sck[p] = 1'b1;
        step(HALF);
        seen = sda_line[p];
        sck[p] = 1'b0;
    endtask

    task automatic send_byte(input logic p, input eeprom_pkg::data_t d, output logic ack);
        eeprom_pkg::data_t sh;
        logic              seen;
        sh = d;
        repeat (8)
        begin
            clock_bit(p, sh[7], seen);
            sh = {sh[6:0], 1'b0};
        end
        clock_bit(p, 1'b1, seen);
        ack = ~seen;
    endtask

    // Master answers with a nack on the ninth clock
    task automatic recv_byte(input logic p, output eeprom_pkg::data_t d);
        logic seen;
        d = '0;
        repeat (8)
        begin
            clock_bit(p, 1'b1, seen);
            d = {d[6:0], seen};
        end
        clock_bit(p, 1'b1, seen);
    endtask

    task automatic bus_write(input logic p, input eeprom_pkg::addr_t a,
                             input eeprom_pkg::data_t d, input string name);
        logic ack;
        send_start(p);
        send_byte(p, {`EE_DEV_CODE, a[10:8], 1'b0}, ack);
        check_ack({name, " control ack"}, 1'b1, ack);
        send_byte(p, a[7:0], ack);
        check_ack({name, " address ack"}, 1'b1, ack);
        send_byte(p, d, ack);
        check_ack({name, " data ack"}, 1'b1, ack);
        send_stop(p);
    endtask

    task automatic bus_read(input logic p, input eeprom_pkg::addr_t a, input string name,
                            output eeprom_pkg::data_t d);
        logic ack;
        send_start(p);
        send_byte(p, {`EE_DEV_CODE, a[10:8], 1'b0}, ack);
        check_ack({name, " control ack"}, 1'b1, ack);
        send_byte(p, a[7:0], ack);
        check_ack({name, " address ack"}, 1'b1, ack);
        send_start(p);
        send_byte(p, {`EE_DEV_CODE, a[10:8], 1'b1}, ack);
        check_ack({name, " read control ack"}, 1'b1, ack);
        recv_byte(p, d);
        send_stop(p);
    endtask

    task automatic write_and_record(input logic p, input eeprom_pkg::addr_t a,
                                    input eeprom_pkg::data_t d, input string name);
        bus_write(p, a, d, name);
        model[a] = d;
    endtask

    task automatic read_and_compare(input logic p, input eeprom_pkg::addr_t a,
                                    input string name);
        eeprom_pkg::data_t got;
        bus_read(p, a, name, got);
        check_byte(name, model[a], got);
    endtask

    // First edge is inside reset, run a few cycles past release
    task automatic check_reset_idle();
        step(1);
        repeat (14)
        begin
            check_ack("reset sda_oe port 0", 1'b0, sda_oe[0]);
            check_ack("reset sda_oe port 1", 1'b0, sda_oe[1]);
            step(1);
        end
    endtask

    task automatic test_write_read();
        logic              p;
        eeprom_pkg::addr_t a;
        string             name;
        for (int i = 0; i < N_WR_RD; i++)
        begin
            p    = rand_port();
            a    = rand_addr();
            name = $sformatf("write_read %0d port %0d addr 11'h%03h", i, p, a);
            write_and_record(p, a, rand_byte(), name);
            read_and_compare(p, a, name);
        end
    endtask

    task automatic test_blocks();
        logic              p;
        eeprom_pkg::data_t a8;
        logic [2:0]        blk;
        p   = rand_port();
        a8  = rand_byte();
        blk = 3'd0;
        repeat (8)
        begin
            write_and_record(p, {blk, a8}, rand_byte(), $sformatf("blocks write blk %0d", blk));
            blk = blk + 3'd1;
        end
        repeat (8)
        begin
            read_and_compare(p, {blk, a8}, $sformatf("blocks read blk %0d", blk));
            blk = blk + 3'd1;
        end
    endtask

    // Slave goes idle, so no byte of the frame may be acknowledged
    task automatic test_bad_code();
        logic              p;
        logic              ack;
        eeprom_pkg::addr_t a;
        logic [31:0]       r;
        logic [3:0]        code;
        string             name;
        for (int i = 0; i < N_BAD; i++)
        begin
            p    = rand_port();
            a    = rand_addr();
            name = $sformatf("bad_code %0d port %0d", i, p);
            write_and_record(p, a, rand_byte(), {name, " setup"});
            r    = $urandom;
            code = r[3:0];
            if (code == `EE_DEV_CODE)
                code = ~code;
            send_start(p);
            send_byte(p, {code, a[10:8], 1'b0}, ack);
            check_ack({name, " control nack"}, 1'b0, ack);
            send_byte(p, a[7:0], ack);
            check_ack({name, " address nack"}, 1'b0, ack);
            send_byte(p, rand_byte(), ack);
            check_ack({name, " data nack"}, 1'b0, ack);
            send_stop(p);
            read_and_compare(p, a, {name, " readback"});
        end
    endtask

    task automatic test_dual();
        for (int i = 0; i < N_DUAL; i++)
        begin
            dual_addr[0] = rand_addr();
            dual_addr[1] = rand_addr();
            while (dual_addr[1] == dual_addr[0])
                dual_addr[1] = rand_addr();
            dual_data[0] = rand_byte();
            dual_data[1] = rand_byte();
            // Same start cycle on both buses, requests collide
            fork
                bus_write(1'b0, dual_addr[0], dual_data[0], "dual write port 0");
                bus_write(1'b1, dual_addr[1], dual_data[1], "dual write port 1");
            join
            model[dual_addr[0]] = dual_data[0];
            model[dual_addr[1]] = dual_data[1];
            // Each port reads what the other wrote
            fork
                bus_read(1'b1, dual_addr[0], "dual read port 1", dual_rd[0]);
                bus_read(1'b0, dual_addr[1], "dual read port 0", dual_rd[1]);
            join
            check_byte("dual read port 1", model[dual_addr[0]], dual_rd[0]);
            check_byte("dual read port 0", model[dual_addr[1]], dual_rd[1]);
        end
    endtask

    // The stop's own sck rise is one more bit, so at most 6 data bits go first
    task automatic test_abort();
        logic              p;
        logic              ack;
        logic              seen;
        eeprom_pkg::addr_t a;
        eeprom_pkg::data_t sh;
        logic [31:0]       r;
        int                nbits;
        string             name;
        for (int i = 0; i < N_ABORT; i++)
        begin
            p     = rand_port();
            a     = rand_addr();
            r     = $urandom;
            nbits = 1 + int'(r % 32'd6);
            name  = $sformatf("abort %0d port %0d after %0d bits", i, p, nbits);
            write_and_record(p, a, rand_byte(), {name, " setup"});
            send_start(p);
            send_byte(p, {`EE_DEV_CODE, a[10:8], 1'b0}, ack);
            check_ack({name, " control ack"}, 1'b1, ack);
            send_byte(p, a[7:0], ack);
            check_ack({name, " address ack"}, 1'b1, ack);
            sh = rand_byte();
            repeat (nbits)
            begin
                clock_bit(p, sh[7], seen);
                sh = {sh[6:0], 1'b0};
            end
            send_stop(p);
            read_and_compare(p, a, {name, " readback"});
        end
    endtask

    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT)
        begin
            @(posedge scl);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial
    begin
        sck     = '1;
        sda_drv = '1;
        void'($urandom(32'h0b059e25));
        check_reset_idle();
        test_write_read();
        test_blocks();
        test_bad_code();
        test_dual();
        test_abort();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- dual_port_eeprom.f
+incdir+.
eeprom_pkg.sv
line_sampler.sv
serial_slave.sv
mem_arbiter.sv
byte_store.sv
dual_port_eeprom.sv
tb_clock.sv
tb_dual_port_eeprom.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the dual-port EEPROM testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_dual_port_eeprom \
    -f dual_port_eeprom.f \
    --Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1
